// ==== bench/program_vectors.txt ====
# P: four program words in address order, the first line at address 0
# S: expected store address and data, in the order the stores occur
P 123450b7 67808093 ffb00113 402081b3  # lui x1, addi x1, addi x2, sub x3
P 10302023 00409213 40115293 01c15313  # sw x3, slli x4, srai x5, srli x6
P 005243b3 0063e3b3 0013f433 10802223  # xor x7, or x7, and x8, sw x8
P 000124b3 00203533 01033593 00659633  # slt x9, sltu x10, sltiu x11, sll x12
P 00960633 00a60633 00001697 00700013  # add x12, add x12, auipc x13, addi x0
P 000686b3 10c02423 10d02623 00b10463  # add x13 x0, sw x12, sw x13, beq not taken
P 00b58463 00170713 00b59463 00b11463  # beq taken, skipped, bne not taken, bne taken
P 00270713 0025c463 00b14463 00470713  # skipped, blt not taken, blt taken, skipped
P 00b15463 0025d463 00870713 00b16463  # bge not taken, bge taken, skipped, bltu not taken
P 0025e463 01070713 0025f463 00b17463  # bltu taken, skipped, bgeu not taken, bgeu taken
P 02070713 010007ef 1e002823 1e002a23  # skipped, jal x15, shadow sw, shadow sw
P 1e002c23 00000817 015808e7 1ef02023  # shadow sw, auipc x16, jalr x17 odd offset, shadow sw
P 1ef02223 1ef02423 00e88933 10f02823  # shadow sw, shadow sw, add x18, sw x15
P 11202a23 0000006f 00000013 00000013  # sw x18, jal to self, nop, nop
# Stores
S 00000100 1234567d
S 00000104 10301078
S 00000108 00008002
S 0000010c 00001048
S 00000110 000000a8
S 00000114 000000bc

// ==== filelist.f ====
verilog/rv32_pkg.sv
verilog/fetch_stage.sv
verilog/decode_unit.sv
verilog/regfile.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/rv32_core.sv
bench/tb_rv32_core.sv

// ==== bench/tb_rv32_core.sv ====
// Self-checking testbench for the RV32I core that also serves as its zero-latency instruction memory
// Runs the vector program twice, first with a steady fetch, then with random fetch gaps

`timescale 1ns/1ps

module tb_rv32_core;
    import rv32_pkg::*;

    localparam int QUIET_CYCLES = 20;

    logic  i_clk;
    logic  i_rst_n;
    logic  i_if_valid;
    word_t i_instr;
    word_t o_pc;
    logic  o_store_req;
    word_t o_data_addr;
    word_t o_data_out;

    // Program image and expected stores, filled from the vector file
    word_t       prog_mem [$];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    logic [31:0] rng_state;
    int          cycle_limit;

    rv32_core u_dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_if_valid  (i_if_valid),
        .i_instr     (i_instr),
        .o_pc        (o_pc),
        .o_store_req (o_store_req),
        .o_data_addr (o_data_addr),
        .o_data_out  (o_data_out)
    );

    // ====================
    // 8 ns clock
    // ====================
    initial begin
        i_clk = 1'b0;
    end

    always #4 i_clk = ~i_clk;

    // ====================
    // Helpers
    // ====================
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch %s: expected %08h, actual %08h", name, expected, actual));
        end
    endtask

    // Fetch gap generator
    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Past the end of the image the memory returns NOPs
    function automatic word_t fetch_word(input word_t pc);
        if (pc[31:2] < prog_mem.size()) begin
            return prog_mem[pc[31:2]];
        end
        return NOP_INSTR;
    endfunction

    // P lines hold four words, S lines an address and data, # starts a comment
    task automatic load_vectors();
        int    fd;
        int    c;
        int    n;
        int    i;
        word_t words [4];
        fd = $fopen("bench/program_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the vector file bench/program_vectors.txt");
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "P") begin
                n = $fscanf(fd, "%h %h %h %h", words[0], words[1], words[2], words[3]);
                if (n != 4) begin
                    fail_run("A program line in the vector file does not hold four words");
                end
                for (i = 0; i < 4; i++) begin
                    prog_mem.push_back(words[i]);
                end
            end else if (c == "S") begin
                n = $fscanf(fd, "%h %h", words[0], words[1]);
                if (n != 2) begin
                    fail_run("A store line in the vector file does not hold address and data");
                end
                exp_addr.push_back(words[0]);
                exp_data.push_back(words[1]);
            end
            // Drop the rest of the line
            while (c != -1 && c != "\n") begin
                c = $fgetc(fd);
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (prog_mem.size() == 0 || exp_addr.size() == 0) begin
            fail_run("The vector file holds no program or no expected stores");
        end
    endtask

    // ====================
    // Reset and pass control
    // ====================
    // Two clock cycles of reset with the outputs checked while held
    task automatic apply_reset();
        i_rst_n    = 1'b0;
        i_if_valid = 1'b0;
        i_instr    = NOP_INSTR;
        repeat (2) begin
            @(negedge i_clk);
            check_value("reset store strobe", 32'd0, {31'b0, o_store_req});
        end
        check_value("reset pc", PC_START, o_pc);
        i_rst_n = 1'b1;
    endtask

    // Inputs change on the falling edge only
    task automatic drive_fetch(input bit gaps);
        if (gaps) begin
            rng_state  = xorshift32(rng_state);
            i_if_valid = (rng_state[1:0] != 2'b00);
        end else begin
            i_if_valid = 1'b1;
        end
        i_instr = fetch_word(o_pc);
    endtask

    // Runs until every store is seen, then stays quiet for a while
    task automatic run_pass(input bit gaps, input string tag);
        int cycles;
        int quiet;
        int idx;
        cycles = 0;
        quiet  = 0;
        idx    = 0;
        while (quiet < QUIET_CYCLES) begin
            drive_fetch(gaps);
            @(negedge i_clk);
            cycles++;
            if (cycles > cycle_limit) begin
                fail_run($sformatf("Timeout in the %s pass, %0d of %0d stores seen",
                                   tag, idx, exp_addr.size()));
            end
            if ($isunknown(o_store_req)) begin
                fail_run("The store strobe went unknown");
            end else if (o_store_req) begin
                if (idx >= exp_addr.size()) begin
                    fail_run($sformatf("Unexpected extra store in the %s pass", tag));
                end
                check_value($sformatf("%s store %0d addr", tag, idx), exp_addr[idx], o_data_addr);
                check_value($sformatf("%s store %0d data", tag, idx), exp_data[idx], o_data_out);
                idx++;
            end else if (idx == exp_addr.size()) begin
                // Strobe-free cycles after the last store
                quiet++;
            end
        end
        $display("%s pass: %0d stores checked in %0d cycles", tag, idx, cycles);
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_if_valid = 1'b0;
        i_instr    = NOP_INSTR;
        rng_state  = 32'h7219;
        load_vectors();
        cycle_limit = 20 * (prog_mem.size() + exp_addr.size()) + 100;
        apply_reset();
        run_pass(1'b0, "steady");
        apply_reset();
        run_pass(1'b1, "gapped");
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== verilog/rv32_core.sv ====
// Top level of the four-stage RV32I core, stage instances only
// Zero-latency instruction source in, word store strobe out

`timescale 1ns/1ps

module rv32_core (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_if_valid,
    input  rv32_pkg::word_t  i_instr,
    output rv32_pkg::word_t  o_pc,
    output logic             o_store_req,
    output rv32_pkg::word_t  o_data_addr,
    output rv32_pkg::word_t  o_data_out
);
    import rv32_pkg::*;

    // ====================
    // Stage wires
    // ====================
    // Decode slot
    word_t     slot_instr;
    word_t     slot_pc;
    // Decoder outputs
    alu_op_e   dec_alu_op;
    br_cond_e  dec_br_cond;
    logic      dec_src_a_pc;
    logic      dec_src_b_imm;
    logic      dec_reg_w;
    logic      dec_mem_w;
    logic      dec_bra;
    logic      dec_jmp;
    logic      dec_indir_jump;
    word_t     dec_imm;
    reg_addr_t dec_rs1_addr;
    reg_addr_t dec_rs2_addr;
    reg_addr_t dec_rd_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    // Execute outputs
    word_t     ex_result;
    word_t     ex_store_data;
    word_t     ex_jump_addr;
    reg_addr_t ex_rd_addr;
    logic      ex_reg_w;
    logic      ex_mem_w;
    logic      ex_take;
    // Redirect and forwarding
    logic      redirect;
    word_t     redirect_addr;
    logic      mem_reg_w;
    reg_addr_t mem_rd_addr;
    word_t     mem_result;
    logic      wb_reg_w;
    reg_addr_t wb_rd_addr;
    word_t     wb_result;

    fetch_stage u_fetch (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_if_valid      (i_if_valid),
        .i_instr         (i_instr),
        .i_redirect      (redirect),
        .i_redirect_addr (redirect_addr),
        .o_pc            (o_pc),
        .o_slot_instr    (slot_instr),
        .o_slot_pc       (slot_pc)
    );

    decode_unit u_decode (
        .i_instr      (slot_instr),
        .o_alu_op     (dec_alu_op),
        .o_br_cond    (dec_br_cond),
        .o_src_a_pc   (dec_src_a_pc),
        .o_src_b_imm  (dec_src_b_imm),
        .o_reg_w      (dec_reg_w),
        .o_mem_w      (dec_mem_w),
        .o_bra        (dec_bra),
        .o_jmp        (dec_jmp),
        .o_indir_jump (dec_indir_jump),
        .o_imm        (dec_imm),
        .o_rs1_addr   (dec_rs1_addr),
        .o_rs2_addr   (dec_rs2_addr),
        .o_rd_addr    (dec_rd_addr)
    );

    // Writeback triple is the write port
    regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_en    (wb_reg_w),
        .i_wr_addr  (wb_rd_addr),
        .i_wr_data  (wb_result),
        .i_rs1_addr (dec_rs1_addr),
        .i_rs2_addr (dec_rs2_addr),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    execute_stage u_execute (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (redirect),
        .i_alu_op      (dec_alu_op),
        .i_br_cond     (dec_br_cond),
        .i_src_a_pc    (dec_src_a_pc),
        .i_src_b_imm   (dec_src_b_imm),
        .i_reg_w       (dec_reg_w),
        .i_mem_w       (dec_mem_w),
        .i_bra         (dec_bra),
        .i_jmp         (dec_jmp),
        .i_indir_jump  (dec_indir_jump),
        .i_imm         (dec_imm),
        .i_rs1_addr    (dec_rs1_addr),
        .i_rs2_addr    (dec_rs2_addr),
        .i_rd_addr     (dec_rd_addr),
        .i_pc          (slot_pc),
        .i_rs1_data    (rs1_data),
        .i_rs2_data    (rs2_data),
        .i_mem_reg_w   (mem_reg_w),
        .i_mem_rd_addr (mem_rd_addr),
        .i_mem_result  (mem_result),
        .i_wb_reg_w    (wb_reg_w),
        .i_wb_rd_addr  (wb_rd_addr),
        .i_wb_result   (wb_result),
        .o_result      (ex_result),
        .o_store_data  (ex_store_data),
        .o_jump_addr   (ex_jump_addr),
        .o_rd_addr     (ex_rd_addr),
        .o_reg_w       (ex_reg_w),
        .o_mem_w       (ex_mem_w),
        .o_take        (ex_take)
    );

    mem_wb_stage u_mem_wb (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_result        (ex_result),
        .i_store_data    (ex_store_data),
        .i_jump_addr     (ex_jump_addr),
        .i_rd_addr       (ex_rd_addr),
        .i_reg_w         (ex_reg_w),
        .i_mem_w         (ex_mem_w),
        .i_take          (ex_take),
        .o_redirect      (redirect),
        .o_redirect_addr (redirect_addr),
        .o_mem_reg_w     (mem_reg_w),
        .o_mem_rd_addr   (mem_rd_addr),
        .o_mem_result    (mem_result),
        .o_wb_reg_w      (wb_reg_w),
        .o_wb_rd_addr    (wb_rd_addr),
        .o_wb_result     (wb_result),
        .o_store_req     (o_store_req),
        .o_data_addr     (o_data_addr),
        .o_data_out      (o_data_out)
    );

endmodule

// ==== verilog/mem_wb_stage.sv ====
// Memory and writeback slots, branch redirect and store strobe
// Also feeds forwarding paths and the regfile write port

`timescale 1ns/1ps

module mem_wb_stage (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  rv32_pkg::word_t      i_result,
    input  rv32_pkg::word_t      i_store_data,
    input  rv32_pkg::word_t      i_jump_addr,
    input  rv32_pkg::reg_addr_t  i_rd_addr,
    input  logic                 i_reg_w,
    input  logic                 i_mem_w,
    input  logic                 i_take,
    output logic                 o_redirect,
    output rv32_pkg::word_t      o_redirect_addr,
    output logic                 o_mem_reg_w,
    output rv32_pkg::reg_addr_t  o_mem_rd_addr,
    output rv32_pkg::word_t      o_mem_result,
    output logic                 o_wb_reg_w,
    output rv32_pkg::reg_addr_t  o_wb_rd_addr,
    output rv32_pkg::word_t      o_wb_result,
    output logic                 o_store_req,
    output rv32_pkg::word_t      o_data_addr,
    output rv32_pkg::word_t      o_data_out
);
    import rv32_pkg::*;

    word_t mem_store_data;

    // ====================
    // Memory slot
    // ====================
    // Younger work entering on a redirect is dropped
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_reg_w <= 1'b0;
            o_store_req <= 1'b0;
            o_redirect  <= 1'b0;
        end else begin
            o_mem_reg_w <= i_reg_w && !o_redirect;
            o_store_req <= i_mem_w && !o_redirect;
            o_redirect  <= i_take  && !o_redirect;
        end
    end

    always_ff @(posedge i_clk) begin
        o_mem_result    <= i_result;
        o_mem_rd_addr   <= i_rd_addr;
        o_redirect_addr <= i_jump_addr;
        mem_store_data  <= i_store_data;
    end

    // Store address is the ALU sum rs1 + offset
    assign o_data_addr = o_mem_result;
    assign o_data_out  = mem_store_data;

    // ====================
    // Writeback slot
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_reg_w <= 1'b0;
        end else begin
            o_wb_reg_w <= o_mem_reg_w;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_rd_addr <= o_mem_rd_addr;
        o_wb_result  <= o_mem_result;
    end

    a_store_known : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(o_store_req));

endmodule

// ==== verilog/execute_stage.sv ====
// Execute stage with forwarding, ALU, branch compare and jump target
// Registers the decode slot, control bits cleared on a redirect

`timescale 1ns/1ps

module execute_stage (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    input  rv32_pkg::alu_op_e    i_alu_op,
    input  rv32_pkg::br_cond_e   i_br_cond,
    input  logic                 i_src_a_pc,
    input  logic                 i_src_b_imm,
    input  logic                 i_reg_w,
    input  logic                 i_mem_w,
    input  logic                 i_bra,
    input  logic                 i_jmp,
    input  logic                 i_indir_jump,
    input  rv32_pkg::word_t      i_imm,
    input  rv32_pkg::reg_addr_t  i_rs1_addr,
    input  rv32_pkg::reg_addr_t  i_rs2_addr,
    input  rv32_pkg::reg_addr_t  i_rd_addr,
    input  rv32_pkg::word_t      i_pc,
    input  rv32_pkg::word_t      i_rs1_data,
    input  rv32_pkg::word_t      i_rs2_data,
    input  logic                 i_mem_reg_w,
    input  rv32_pkg::reg_addr_t  i_mem_rd_addr,
    input  rv32_pkg::word_t      i_mem_result,
    input  logic                 i_wb_reg_w,
    input  rv32_pkg::reg_addr_t  i_wb_rd_addr,
    input  rv32_pkg::word_t      i_wb_result,
    output rv32_pkg::word_t      o_result,
    output rv32_pkg::word_t      o_store_data,
    output rv32_pkg::word_t      o_jump_addr,
    output rv32_pkg::reg_addr_t  o_rd_addr,
    output logic                 o_reg_w,
    output logic                 o_mem_w,
    output logic                 o_take
);
    import rv32_pkg::*;

    // Pipeline registers
    alu_op_e   ex_alu_op;
    br_cond_e  ex_br_cond;
    logic      ex_src_a_pc;
    logic      ex_src_b_imm;
    logic      ex_bra;
    logic      ex_jmp;
    logic      ex_indir_jump;
    word_t     ex_imm;
    word_t     ex_pc;
    word_t     ex_rs1_data;
    word_t     ex_rs2_data;
    reg_addr_t ex_rs1_addr;
    reg_addr_t ex_rs2_addr;

    // Datapath
    word_t rs1_fwd;
    word_t rs2_fwd;
    word_t alu_a;
    word_t alu_b;
    word_t alu_out;
    word_t jump_sum;
    logic  cond_true;

    // ====================
    // Slot registers
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_reg_w <= 1'b0;
            o_mem_w <= 1'b0;
            ex_bra  <= 1'b0;
            ex_jmp  <= 1'b0;
        end else begin
            o_reg_w <= i_reg_w && !i_flush;
            o_mem_w <= i_mem_w && !i_flush;
            ex_bra  <= i_bra   && !i_flush;
            ex_jmp  <= i_jmp   && !i_flush;
        end
    end

    always_ff @(posedge i_clk) begin
        ex_alu_op     <= i_alu_op;
        ex_br_cond    <= i_br_cond;
        ex_src_a_pc   <= i_src_a_pc;
        ex_src_b_imm  <= i_src_b_imm;
        ex_indir_jump <= i_indir_jump;
        ex_imm        <= i_imm;
        ex_pc         <= i_pc;
        ex_rs1_data   <= i_rs1_data;
        ex_rs2_data   <= i_rs2_data;
        ex_rs1_addr   <= i_rs1_addr;
        ex_rs2_addr   <= i_rs2_addr;
        o_rd_addr     <= i_rd_addr;
    end

    // ====================
    // Forwarding
    // ====================
    // Memory slot is younger, so it wins over writeback
    assign rs1_fwd = (i_mem_reg_w && i_mem_rd_addr == ex_rs1_addr) ? i_mem_result :
                     (i_wb_reg_w  && i_wb_rd_addr  == ex_rs1_addr) ? i_wb_result  :
                                                                     ex_rs1_data;
    assign rs2_fwd = (i_mem_reg_w && i_mem_rd_addr == ex_rs2_addr) ? i_mem_result :
                     (i_wb_reg_w  && i_wb_rd_addr  == ex_rs2_addr) ? i_wb_result  :
                                                                     ex_rs2_data;

    // ====================
    // ALU
    // ====================
    assign alu_a = ex_src_a_pc  ? ex_pc  : rs1_fwd;
    assign alu_b = ex_src_b_imm ? ex_imm : rs2_fwd;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD:    alu_out = alu_a + alu_b;
            ALU_SUB:    alu_out = alu_a - alu_b;
            ALU_SLL:    alu_out = alu_a << alu_b[4:0];
            ALU_SLT:    alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU:   alu_out = {31'b0, alu_a < alu_b};
            ALU_XOR:    alu_out = alu_a ^ alu_b;
            ALU_SRL:    alu_out = alu_a >> alu_b[4:0];
            ALU_SRA:    alu_out = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            ALU_OR:     alu_out = alu_a | alu_b;
            ALU_AND:    alu_out = alu_a & alu_b;
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = '0;
        endcase
    end

    // Jumps write the link address
    assign o_result     = ex_jmp ? ex_pc + 32'd4 : alu_out;
    assign o_store_data = rs2_fwd;

    // ====================
    // Branch and jump
    // ====================
    always_comb begin
        case (ex_br_cond)
            BR_BEQ:  cond_true = (rs1_fwd == rs2_fwd);
            BR_BNE:  cond_true = (rs1_fwd != rs2_fwd);
            BR_BLT:  cond_true = ($signed(rs1_fwd) <  $signed(rs2_fwd));
            BR_BGE:  cond_true = ($signed(rs1_fwd) >= $signed(rs2_fwd));
            BR_BLTU: cond_true = (rs1_fwd <  rs2_fwd);
            BR_BGEU: cond_true = (rs1_fwd >= rs2_fwd);
            default: cond_true = 1'b0;
        endcase
    end

    assign o_take = ex_jmp || (ex_bra && cond_true);

    // JALR clears bit 0 of the target
    assign jump_sum    = (ex_indir_jump ? rs1_fwd : ex_pc) + ex_imm;
    assign o_jump_addr = ex_indir_jump ? {jump_sum[31:1], 1'b0} : jump_sum;

endmodule

// ==== verilog/regfile.sv ====
// Integer register file x1..x31, two async read ports, one write port
// A same-cycle write shows on the read ports

`timescale 1ns/1ps

module regfile (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_wr_en,
    input  rv32_pkg::reg_addr_t  i_wr_addr,
    input  rv32_pkg::word_t      i_wr_data,
    input  rv32_pkg::reg_addr_t  i_rs1_addr,
    input  rv32_pkg::reg_addr_t  i_rs2_addr,
    output rv32_pkg::word_t      o_rs1_data,
    output rv32_pkg::word_t      o_rs2_data
);
    import rv32_pkg::*;

    word_t regs [1:31];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_addr != '0) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // x0 reads zero, then write-through, then array
    assign o_rs1_data = (i_rs1_addr == '0)                      ? '0        :
                        (i_wr_en && i_wr_addr == i_rs1_addr)    ? i_wr_data :
                                                                  regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0)                      ? '0        :
                        (i_wr_en && i_wr_addr == i_rs2_addr)    ? i_wr_data :
                                                                  regs[i_rs2_addr];

    // Decode drops rd=x0 writes before they reach writeback
    a_no_x0_write : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_wr_en && i_wr_addr == '0));

endmodule

// ==== verilog/decode_unit.sv ====
// Combinational decoder and immediate generator for the decode slot
// Illegal and unsupported encodings come out as bubbles

`timescale 1ns/1ps

module decode_unit (
    input  rv32_pkg::word_t      i_instr,
    output rv32_pkg::alu_op_e    o_alu_op,
    output rv32_pkg::br_cond_e   o_br_cond,
    output logic                 o_src_a_pc,
    output logic                 o_src_b_imm,
    output logic                 o_reg_w,
    output logic                 o_mem_w,
    output logic                 o_bra,
    output logic                 o_jmp,
    output logic                 o_indir_jump,
    output rv32_pkg::word_t      o_imm,
    output rv32_pkg::reg_addr_t  o_rs1_addr,
    output rv32_pkg::reg_addr_t  o_rs2_addr,
    output rv32_pkg::reg_addr_t  o_rd_addr
);
    import rv32_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rd_write;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // ALU op from funct3, alt selects SUB or SRA
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // ====================
    // Fields and immediates
    // ====================
    assign opcode     = i_instr[6:0];
    assign funct3     = i_instr[14:12];
    assign funct7     = i_instr[31:25];
    assign o_rd_addr  = i_instr[11:7];
    assign o_rs1_addr = i_instr[19:15];
    assign o_rs2_addr = i_instr[24:20];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                    i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                    i_instr[20], i_instr[30:21], 1'b0};

    // No register writes to x0
    assign o_reg_w = rd_write && (o_rd_addr != '0);

    // ====================
    // Control decode
    // ====================
    always_comb begin
        o_alu_op     = ALU_ADD;
        o_br_cond    = BR_BEQ;
        o_src_a_pc   = 1'b0;
        o_src_b_imm  = 1'b0;
        rd_write     = 1'b0;
        o_mem_w      = 1'b0;
        o_bra        = 1'b0;
        o_jmp        = 1'b0;
        o_indir_jump = 1'b0;
        o_imm        = imm_i;
        case (opcode)
            OPC_OP: begin
                // funct7 5 only legal for SUB and SRA
                if (funct7 == 7'b0 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    o_alu_op = alu_sel(funct3, funct7[5]);
                    rd_write = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                // Shift-immediates carry funct7 in the upper bits
                if ((funct3 != 3'b001 && funct3 != 3'b101) ||
                    (funct3 == 3'b001 && funct7 == 7'b0) ||
                    (funct3 == 3'b101 && (funct7 == 7'b0 || funct7 == 7'b0100000))) begin
                    o_alu_op    = alu_sel(funct3, funct7[5] && funct3 == 3'b101);
                    o_src_b_imm = 1'b1;
                    rd_write    = 1'b1;
                end
            end
            OPC_LUI: begin
                o_alu_op    = ALU_PASS_B;
                o_src_b_imm = 1'b1;
                o_imm       = imm_u;
                rd_write    = 1'b1;
            end
            OPC_AUIPC: begin
                o_src_a_pc  = 1'b1;
                o_src_b_imm = 1'b1;
                o_imm       = imm_u;
                rd_write    = 1'b1;
            end
            OPC_BRANCH: begin
                // funct3 2 and 3 are not branches
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    o_br_cond = br_cond_e'(funct3);
                    o_bra     = 1'b1;
                    o_imm     = imm_b;
                end
            end
            OPC_JAL: begin
                o_jmp    = 1'b1;
                o_imm    = imm_j;
                rd_write = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    o_jmp        = 1'b1;
                    o_indir_jump = 1'b1;
                    rd_write     = 1'b1;
                end
            end
            OPC_STORE: begin
                // Word stores only
                if (funct3 == 3'b010) begin
                    o_mem_w     = 1'b1;
                    o_src_b_imm = 1'b1;
                    o_imm       = imm_s;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/fetch_stage.sv ====
// Program counter and decode-slot register of the core
// Stalls on an invalid instruction source, redirect takes priority

`timescale 1ns/1ps

module fetch_stage (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_if_valid,
    input  rv32_pkg::word_t  i_instr,
    input  logic             i_redirect,
    input  rv32_pkg::word_t  i_redirect_addr,
    output rv32_pkg::word_t  o_pc,
    output rv32_pkg::word_t  o_slot_instr,
    output rv32_pkg::word_t  o_slot_pc
);
    import rv32_pkg::*;

    // PC and decode slot move together
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc         <= PC_START;
            o_slot_instr <= NOP_INSTR;
            o_slot_pc    <= PC_START;
        end else if (i_redirect) begin
            // Taken transfer from the memory slot
            o_pc         <= i_redirect_addr;
            o_slot_instr <= NOP_INSTR;
        end else if (!i_if_valid) begin
            // Hold PC, bubble into decode
            o_slot_instr <= NOP_INSTR;
        end else begin
            o_pc         <= o_pc + 32'd4;
            o_slot_instr <= i_instr;
            o_slot_pc    <= o_pc;
        end
    end

    // Targets from execute must keep fetch word aligned
    a_pc_aligned : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_pc[1:0] == 2'b00);

endmodule

// ==== verilog/rv32_pkg.sv ====
// Shared widths, opcodes and enums for the four-stage RV32I core
// Each RTL module pulls this in with a wildcard import in its body

package rv32_pkg;

    // ====================
    // Widths and reset values
    // ====================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Fetch address after reset
    localparam word_t PC_START  = 32'h0000_0000;
    // addi x0,x0,0 fills a flushed or empty decode slot
    localparam word_t NOP_INSTR = 32'h0000_0013;

    // ====================
    // Opcodes of the kept classes
    // ====================
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // ALU operations, LUI goes through PASS_B
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // Branch conditions, values equal to the branch funct3
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_cond_e;

endpackage
